//--- project.f
+incdir+hw
hw/rp_pkg.sv
hw/rpControl.sv
hw/rpOffset.sv
hw/rpAddress.sv
hw/rpRegs.sv
tests/rpRegs_props.sv
tests/rpRegs_tb.sv

//--- Makefile
# Verilator build, run and lint for the RP register file

VERILATOR  ?= verilator
TOP        ?= rpRegs_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
RUN_ARGS   ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulator is the test result
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/rpRegs_tb.sv
// RP register file testbench
// Drives the register port with LFSR data, keeps a small model of
// the register rules and checks each read return against it

`timescale 1ns/1ps

`include "rp_config.svh"

module rpRegs_tb;

   localparam int AckLimit  = 8;
   localparam int SeekLimit = 4 * `RP_SEEK_CYCLES;

   logic           clk;
   logic           rpPRESET;
   rp_pkg::rpBus_t bus;
   logic [15:0]    rdData;
   logic           rdAck;
   logic           ata;
   logic [31:0]    lfsr;

   // Model of the register contents
   logic       mFmt22;
   logic       mEci;
   logic       mHci;
   logic       mOfd;
   logic [6:0] mOfs;
   logic [4:0] mTrack;
   logic [4:0] mSector;
   logic [9:0] mCyl;
   logic [4:0] mCs1Fun;
   logic       mAta;
   logic       mIlf;
   logic       mIae;
   logic       mDry;

   rpRegs rpRegs_inst
   (
      .clk      (clk),
      .rpPRESET (rpPRESET),
      .bus      (bus),
      .rdData   (rdData),
      .rdAck    (rdAck),
      .ata      (ata)
   );

   bind rpRegs rpRegs_props rpRegs_props_inst
   (
      .clk      (clk),
      .rpPRESET (rpPRESET),
      .bus      (bus),
      .rdAck    (rdAck),
      .cmd      (cmd),
      .dry      (dry)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////
   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic randBits(input int n, output logic [35:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsrNext(lfsr);
         v    = {v[34:0], lfsr[0]};
      end
   endtask

   task automatic stopRun(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic clearOffset();
      mOfd = 1'b0;
      mOfs = '0;
   endtask

   task automatic clearModel();
      {mFmt22, mEci, mHci} = '0;
      clearOffset();
      {mTrack, mSector, mCyl, mCs1Fun} = '0;
      {mAta, mIlf, mIae} = '0;
      mDry = 1'b1;
   endtask

   // Busy drive takes drive clear only
   task automatic modelFunction(input logic [5:0] fun);
      logic cylOk;
      cylOk = mCyl <= `RP_CYL_MAX;
      if (mDry || fun == `RP_FUN_DRVCLR)
      begin
         mCs1Fun = fun[5:1];
         if (fun[0])
         begin
            case (fun)
               // No register side effect
               `RP_FUN_NOP, `RP_FUN_OFFSET:
                  ;
               `RP_FUN_DRVCLR:
               begin
                  {mAta, mIlf, mIae} = '0;
                  clearOffset();
               end
               `RP_FUN_CENTER, `RP_FUN_WRITE, `RP_FUN_WRITEH:
                  clearOffset();
               `RP_FUN_PRESET:
               begin
                  {mFmt22, mEci, mHci} = '0;
                  clearOffset();
                  {mTrack, mSector, mCyl} = '0;
               end
               `RP_FUN_SEEK:
               begin
                  if (cylOk)
                  begin
                     clearOffset();
                     mDry = 1'b0;
                  end
                  else
                     mIae = 1'b1;
               end
               default:
                  mIlf = 1'b1;
            endcase
         end
      end
   endtask

   task automatic modelWrite(input logic [4:0] addr, input logic [35:0] data);
      case (addr)
         `RP_ADDR_OF:
            if (mDry)
            begin
               {mFmt22, mEci, mHci} = data[12:10];
               mOfd = data[7];
               mOfs = data[6:0];
            end
         `RP_ADDR_DA:
            if (mDry)
            begin
               mTrack  = data[12:8];
               mSector = data[4:0];
            end
         `RP_ADDR_DC:
            if (mDry)
               mCyl = data[9:0];
         `RP_ADDR_CS1:
            modelFunction(data[5:0]);
         // Other addresses hold nothing
         default:
            ;
      endcase
   endtask

   // Expected read value per address
   function automatic logic [15:0] modelRead(input logic [4:0] addr);
      case (addr)
         `RP_ADDR_CS1: return {10'b0, mCs1Fun, ~mDry};
         `RP_ADDR_DS:  return {mAta, mIlf, mIae, 5'b0, mDry, 7'b0};
         `RP_ADDR_DA:  return {3'b0, mTrack, 3'b0, mSector};
         `RP_ADDR_OF:  return {3'b0, mFmt22, mEci, mHci, 2'b0, mOfd, mOfs};
         `RP_ADDR_DC:  return {6'b0, mCyl};
         default:      return '0;
      endcase
   endfunction

   ////////////////////
   // Bus tasks
   ////////////////////
   task automatic writeReg(input logic [4:0] addr, input logic [35:0] data);
      bus.wrStb = 1'b1;
      bus.addr  = addr;
      bus.data  = data;
      @(posedge clk);
      #1;
      bus.wrStb = 1'b0;
      modelWrite(addr, data);
   endtask

   // Datapath changes one cycle after the CS1 write
   task automatic doFunction(input logic [5:0] fun);
      writeReg(`RP_ADDR_CS1, {30'b0, fun});
      idle(1);
   endtask

   task automatic readReg(input logic [4:0] addr, output logic [15:0] data);
      int waitCnt;
      bus.rdStb = 1'b1;
      bus.addr  = addr;
      @(posedge clk);
      #1;
      bus.rdStb = 1'b0;
      waitCnt   = 0;
      while (!rdAck && waitCnt < AckLimit)
      begin
         @(posedge clk);
         #1;
         waitCnt++;
      end
      if (rdAck)
         data = rdData;
      else
         stopRun("Timed out waiting for a read acknowledge");
   endtask

   task automatic checkReg(input logic [4:0] addr);
      logic [15:0] got;
      logic [15:0] want;
      want = modelRead(addr);
      readReg(addr, got);
      assert (got == want)
      else
         stopRun($sformatf("error at %0t ns: register %0o read %h, expected %h",
                           $time, addr, got, want));
   endtask

   task automatic checkAll();
      logic [4:0] addrList [5];
      addrList = '{`RP_ADDR_CS1, `RP_ADDR_DS, `RP_ADDR_DA, `RP_ADDR_OF, `RP_ADDR_DC};
      foreach (addrList[i])
         checkReg(addrList[i]);
      assert (ata == mAta)
      else
         stopRun($sformatf("error at %0t ns: ata port %b, expected %b", $time, ata, mAta));
   endtask

   // Poll DS until drive ready comes back
   task automatic waitReady();
      logic [15:0] ds;
      int          pollCnt;
      pollCnt = 0;
      readReg(`RP_ADDR_DS, ds);
      while (!ds[7] && pollCnt < SeekLimit)
      begin
         readReg(`RP_ADDR_DS, ds);
         pollCnt++;
      end
      if (ds[7])
      begin
         mDry = 1'b1;
         mAta = 1'b1;
      end
      else
         stopRun("Timed out waiting for drive ready after a seek");
   endtask

   task automatic resetDut();
      rpPRESET = 1'b1;
      idle(10);
      rpPRESET = 1'b0;
      clearModel();
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial
   begin
      logic [35:0] r;
      logic [5:0]  clrFuns [5];
      clrFuns  = '{`RP_FUN_CENTER, `RP_FUN_SEEK, `RP_FUN_WRITE, `RP_FUN_WRITEH,
                   `RP_FUN_DRVCLR};
      rpPRESET = 1'b1;
      bus      = '0;
      lfsr     = 32'h8867_d55c;
      resetDut();

      // Reset values of every register and an unused address
      checkAll();
      checkReg(5'o03);

      // Random field loads
      for (int i = 0; i < 8; i++)
      begin
         randBits(36, r);
         writeReg(`RP_ADDR_OF, r);
         randBits(36, r);
         writeReg(`RP_ADDR_DA, r);
         randBits(36, r);
         writeReg(`RP_ADDR_DC, r);
         checkAll();
      end

      // Offset clearing functions keep the mode bits
      foreach (clrFuns[i])
      begin
         randBits(9, r);
         writeReg(`RP_ADDR_DC, r);
         randBits(36, r);
         writeReg(`RP_ADDR_OF, r | 36'h1c81);
         doFunction(clrFuns[i]);
         if (clrFuns[i] == `RP_FUN_SEEK)
            waitReady();
         checkAll();
      end

      // Preset wipes OF, DA and DC
      randBits(9, r);
      writeReg(`RP_ADDR_DC, r | 36'h1);
      randBits(36, r);
      writeReg(`RP_ADDR_DA, r | 36'h0101);
      randBits(36, r);
      writeReg(`RP_ADDR_OF, r | 36'h1c00);
      checkAll();
      doFunction(`RP_FUN_PRESET);
      checkAll();

      // Legal seek then writes while busy
      randBits(9, r);
      writeReg(`RP_ADDR_DC, r);
      randBits(36, r);
      writeReg(`RP_ADDR_OF, r);
      randBits(36, r);
      writeReg(`RP_ADDR_DA, r);
      doFunction(`RP_FUN_SEEK);
      checkReg(`RP_ADDR_DS);
      checkReg(`RP_ADDR_CS1);
      randBits(36, r);
      writeReg(`RP_ADDR_OF, r);
      randBits(36, r);
      writeReg(`RP_ADDR_DA, r);
      randBits(36, r);
      writeReg(`RP_ADDR_DC, r);
      doFunction(`RP_FUN_CENTER);
      checkReg(`RP_ADDR_OF);
      checkReg(`RP_ADDR_DA);
      checkReg(`RP_ADDR_DC);
      waitReady();
      checkAll();

      // Cylinder out of range and unknown codes before drive clear
      randBits(7, r);
      writeReg(`RP_ADDR_DC, 36'd815 + r);
      doFunction(`RP_FUN_SEEK);
      checkAll();
      doFunction(6'o07);
      checkAll();
      doFunction(6'o43);
      checkAll();
      doFunction(`RP_FUN_DRVCLR);
      checkAll();

      // Every status flag up before a reset in the middle of a run
      randBits(9, r);
      writeReg(`RP_ADDR_DC, r);
      doFunction(`RP_FUN_SEEK);
      waitReady();
      randBits(7, r);
      writeReg(`RP_ADDR_DC, 36'd815 + r);
      doFunction(`RP_FUN_SEEK);
      doFunction(6'o07);
      checkAll();

      randBits(36, r);
      writeReg(`RP_ADDR_OF, r | 36'h1c81);
      randBits(36, r);
      writeReg(`RP_ADDR_DA, r);
      randBits(36, r);
      writeReg(`RP_ADDR_DC, r);
      resetDut();
      checkAll();
      checkReg(5'o03);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- tests/rpRegs_props.sv
// RP register file timing properties
// Read acknowledge timing, quiet command strobes in reset
// and the upper bound on a seek

`timescale 1ns/1ps

`include "rp_config.svh"

module rpRegs_props
(
   input logic           clk,
   input logic           rpPRESET,
   input rp_pkg::rpBus_t bus,
   input logic           rdAck,
   input rp_pkg::rpCmd_t cmd,
   input logic           dry
);

   logic [7:0] seekAge;

   // Cycles since the seek strobe, while busy
   always_ff @(posedge clk)
   begin
      if (rpPRESET)
         seekAge <= '0;
      else if (cmd.cmdSeek)
         seekAge <= 8'd1;
      else if (seekAge != '0 && !dry)
         seekAge <= seekAge + 8'd1;
      else
         seekAge <= '0;
   end

   ////////////////////
   // Read port
   ////////////////////
   ackAfterStb: assert property (@(posedge clk) disable iff (rpPRESET) bus.rdStb |=> rdAck)
      else $error("rdAck missing one cycle after rdStb");

   ackOnlyForStb: assert property (@(posedge clk) disable iff (rpPRESET)
                                   rdAck |-> $past(bus.rdStb))
      else $error("rdAck without a read strobe one cycle earlier");

   ////////////////////
   // Commands and seek
   ////////////////////
   strobesQuiet: assert property (@(posedge clk) rpPRESET |=> cmd == '0)
      else $error("command strobe high while in reset");

   // Busy starts right after the strobe
   seekGoesBusy: assert property (@(posedge clk) disable iff (rpPRESET) cmd.cmdSeek |=> !dry)
      else $error("drive still ready after a seek strobe");

   seekBounded: assert property (@(posedge clk) disable iff (rpPRESET)
                                 seekAge <= 8'(`RP_SEEK_CYCLES + 2))
      else $error("drive ready late after a seek");

endmodule

//--- hw/rpRegs.sv
// RP drive register file top
// Control and status on one side, offset and desired address
// registers on the other, all fed from the same register port

`timescale 1ns/1ps

module rpRegs
(
   input  logic              clk,
   input  logic              rpPRESET,
   input  rp_pkg::rpBus_t    bus,
   output logic [15:0]       rdData,
   output logic              rdAck,
   output logic              ata
);

   // Control to datapath
   rp_pkg::rpCmd_t cmd;
   logic           dry;

   // Datapath back to the read mux
   rp_pkg::rpOf_t  of;
   rp_pkg::rpDa_t  da;
   logic [15:0]    dc;

   ////////////////////
   // Control and status
   ////////////////////
   rpControl rpControl_inst
   (
      .clk      (clk),
      .rpPRESET (rpPRESET),
      .bus      (bus),
      .of       (of),
      .da       (da),
      .dc       (dc),
      .cmd      (cmd),
      .dry      (dry),
      .rdData   (rdData),
      .rdAck    (rdAck),
      .ata      (ata)
   );

   // Offset register
   rpOffset rpOffset_inst
   (
      .clk      (clk),
      .rpPRESET (rpPRESET),
      .bus      (bus),
      .cmd      (cmd),
      .dry      (dry),
      .of       (of)
   );

   // Desired address registers
   rpAddress rpAddress_inst
   (
      .clk      (clk),
      .rpPRESET (rpPRESET),
      .bus      (bus),
      .cmd      (cmd),
      .dry      (dry),
      .da       (da),
      .dc       (dc)
   );

endmodule

//--- hw/rpAddress.sv
// RP desired address registers
// DA holds the desired track and sector, DC the desired cylinder;
// both take writes only while the drive is ready and clear on preset

`timescale 1ns/1ps

`include "rp_config.svh"

module rpAddress
(
   input  logic              clk,
   input  logic              rpPRESET,
   input  rp_pkg::rpBus_t    bus,
   input  rp_pkg::rpCmd_t    cmd,
   input  logic              dry,
   output rp_pkg::rpDa_t     da,
   output logic [15:0]       dc
);

   logic       daWr;
   logic       dcWr;
   logic [4:0] track;
   logic [4:0] sector;
   logic [9:0] cyl;

   // Write decode, gated by drive ready
   assign daWr = bus.wrStb && (bus.addr == `RP_ADDR_DA) && dry;
   assign dcWr = bus.wrStb && (bus.addr == `RP_ADDR_DC) && dry;

   ////////////////////
   // Track and sector
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET || cmd.cmdPreset)
      begin
         track  <= '0;
         sector <= '0;
      end
      else if (daWr)
      begin
         track  <= bus.data[12:8];
         sector <= bus.data[4:0];
      end
   end

   // Cylinder, range checked in control
   always_ff @(posedge clk)
   begin
      if (rpPRESET || cmd.cmdPreset)
         cyl <= '0;
      else if (dcWr)
         cyl <= bus.data[9:0];
   end

   assign da = '{rsvd15: 3'b0, track: track, rsvd7: 3'b0, sector: sector};
   assign dc = {6'b0, cyl};

endmodule

//--- hw/rpOffset.sv
// RP offset register (OF)
// Format, ECC inhibit and header inhibit bits survive most commands;
// the head offset direction and amount are dropped by any command
// that moves or recenters the heads

`timescale 1ns/1ps

`include "rp_config.svh"

module rpOffset
(
   input  logic              clk,
   input  logic              rpPRESET,
   input  rp_pkg::rpBus_t    bus,
   input  rp_pkg::rpCmd_t    cmd,
   input  logic              dry,
   output rp_pkg::rpOf_t     of
);

   logic       ofWr;
   logic       ofClr;
   logic       fmt22;
   logic       eci;
   logic       hci;
   logic       ofd;
   logic [6:0] ofs;

   // Only loads on a ready drive
   assign ofWr  = bus.wrStb && (bus.addr == `RP_ADDR_OF) && dry;

   // Any head motion or clear cancels the offset
   assign ofClr = cmd.cmdPreset | cmd.devReset | cmd.cmdCenter |
                  cmd.cmdSeek | cmd.cmdWrite | cmd.cmdWriteH;

   ////////////////////
   // Mode bits
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET || cmd.cmdPreset)
      begin
         fmt22 <= 1'b0;
         eci   <= 1'b0;
         hci   <= 1'b0;
      end
      else if (ofWr)
      begin
         fmt22 <= bus.data[12];
         eci   <= bus.data[11];
         hci   <= bus.data[10];
      end
   end

   ////////////////////
   // Head offset
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET || ofClr)
      begin
         ofd <= 1'b0;
         ofs <= '0;
      end
      else if (ofWr)
      begin
         ofd <= bus.data[7];
         ofs <= bus.data[6:0];
      end
   end

   // Reserved bits read zero
   assign of = '{rsvd15: 3'b0, fmt22: fmt22, eci: eci, hci: hci,
                 rsvd9: 2'b0, ofd: ofd, ofs: ofs};

endmodule

//--- hw/rpControl.sv
// RP drive control
// Decodes CS1 functions into one-cycle command strobes, runs the
// seek timer that owns drive ready, keeps the status bits and
// returns register reads one cycle after the strobe

`timescale 1ns/1ps

`include "rp_config.svh"

module rpControl
(
   input  logic              clk,
   input  logic              rpPRESET,
   input  rp_pkg::rpBus_t    bus,
   input  rp_pkg::rpOf_t     of,
   input  rp_pkg::rpDa_t     da,
   input  logic [15:0]       dc,
   output rp_pkg::rpCmd_t    cmd,
   output logic              dry,
   output logic [15:0]       rdData,
   output logic              rdAck,
   output logic              ata
);

   localparam int SeekW = $clog2(`RP_SEEK_CYCLES);

   logic             cs1Wr;
   logic             cs1Acc;
   logic             goCmd;
   logic             drvClr;
   logic             funLegal;
   logic             seekOk;
   logic [5:0]       funCode;
   logic [4:0]       cs1Fun;
   logic             ilf;
   logic             iae;
   logic [SeekW-1:0] seekCnt;
   rp_pkg::rpDs_t    ds;

   ////////////////////
   // Function decode
   ////////////////////
   assign funCode = bus.data[5:0];
   assign cs1Wr   = bus.wrStb && (bus.addr == `RP_ADDR_CS1);
   // Busy drive only takes drive clear
   assign cs1Acc  = cs1Wr && (dry || funCode == `RP_FUN_DRVCLR);
   // Go bit starts the function
   assign goCmd   = cs1Acc && funCode[0];
   assign drvClr  = goCmd && (funCode == `RP_FUN_DRVCLR);
   assign seekOk  = dc <= 16'(`RP_CYL_MAX);

   always_comb
   begin
      case (funCode)
         `RP_FUN_NOP, `RP_FUN_SEEK, `RP_FUN_DRVCLR, `RP_FUN_OFFSET,
         `RP_FUN_CENTER, `RP_FUN_PRESET, `RP_FUN_WRITE, `RP_FUN_WRITEH:
            funLegal = 1'b1;
         default:
            funLegal = 1'b0;
      endcase
   end

   // Strobes go out the cycle after the CS1 write
   always_ff @(posedge clk)
   begin
      if (rpPRESET)
      begin
         cmd <= '0;
      end
      else
      begin
         cmd <= '0;
         if (goCmd)
         begin
            case (funCode)
               `RP_FUN_DRVCLR: cmd.devReset  <= 1'b1;
               `RP_FUN_CENTER: cmd.cmdCenter <= 1'b1;
               `RP_FUN_PRESET: cmd.cmdPreset <= 1'b1;
               // Out of range seek never starts
               `RP_FUN_SEEK:   cmd.cmdSeek   <= seekOk;
               `RP_FUN_WRITE:  cmd.cmdWrite  <= 1'b1;
               `RP_FUN_WRITEH: cmd.cmdWriteH <= 1'b1;
               default:        cmd           <= '0;
            endcase
         end
      end
   end

   ////////////////////
   // CS1 and error flags
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET)
      begin
         cs1Fun <= '0;
         ilf    <= 1'b0;
         iae    <= 1'b0;
      end
      else
      begin
         if (cs1Acc)
            cs1Fun <= funCode[5:1];
         if (drvClr)
         begin
            ilf <= 1'b0;
            iae <= 1'b0;
         end
         else if (goCmd)
         begin
            // Unknown code
            if (!funLegal)
               ilf <= 1'b1;
            // Cylinder past the last one
            if (funCode == `RP_FUN_SEEK && !seekOk)
               iae <= 1'b1;
         end
      end
   end

   ////////////////////
   // Seek timer
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET)
      begin
         dry     <= 1'b1;
         ata     <= 1'b0;
         seekCnt <= '0;
      end
      else
      begin
         if (drvClr)
            ata <= 1'b0;
         if (cmd.cmdSeek)
         begin
            dry     <= 1'b0;
            seekCnt <= SeekW'(`RP_SEEK_CYCLES - 1);
         end
         else if (!dry)
         begin
            // Seek done, raise attention with ready
            if (seekCnt == '0)
            begin
               dry <= 1'b1;
               ata <= 1'b1;
            end
            else
               seekCnt <= seekCnt - 1'b1;
         end
      end
   end

   // Status word
   assign ds = '{ata: ata, ilf: ilf, iae: iae, rsvd12: 5'b0, dry: dry, rsvd6: 7'b0};

   ////////////////////
   // Read path
   ////////////////////
   always_ff @(posedge clk)
   begin
      if (rpPRESET)
         rdAck <= 1'b0;
      else
         rdAck <= bus.rdStb;
   end

   // Go bit reads back as busy
   always_ff @(posedge clk)
   begin
      if (bus.rdStb)
      begin
         case (bus.addr)
            `RP_ADDR_CS1: rdData <= {10'b0, cs1Fun, ~dry};
            `RP_ADDR_DS:  rdData <= ds;
            `RP_ADDR_DA:  rdData <= da;
            `RP_ADDR_OF:  rdData <= of;
            `RP_ADDR_DC:  rdData <= dc;
            default:      rdData <= '0;
         endcase
      end
   end

endmodule

//--- hw/rp_pkg.sv
// RP drive shared types
// Bus request, command strobes and the register field layouts
// of OF, DA and DS

package rp_pkg;

   // Register port request, one per cycle
   typedef struct packed
   {
      logic        wrStb;
      logic        rdStb;
      logic [4:0]  addr;
      logic [35:0] data;
   } rpBus_t;

   // One-cycle command strobes from the function decoder
   typedef struct packed
   {
      logic devReset;
      logic cmdCenter;
      logic cmdPreset;
      logic cmdSeek;
      logic cmdWrite;
      logic cmdWriteH;
   } rpCmd_t;

   ////////////////////
   // Offset register
   ////////////////////
   typedef struct packed
   {
      logic [2:0] rsvd15;
      logic       fmt22;
      logic       eci;
      logic       hci;
      logic [1:0] rsvd9;
      logic       ofd;
      logic [6:0] ofs;
   } rpOf_t;

   // Desired track and sector
   typedef struct packed
   {
      logic [2:0] rsvd15;
      logic [4:0] track;
      logic [2:0] rsvd7;
      logic [4:0] sector;
   } rpDa_t;

   // Drive status, unused bits read zero
   typedef struct packed
   {
      logic       ata;
      logic       ilf;
      logic       iae;
      logic [4:0] rsvd12;
      logic       dry;
      logic [6:0] rsvd6;
   } rpDs_t;

endpackage

//--- hw/rp_config.svh
// RP drive register file configuration
// Massbus register addresses, CS1 function codes (go bit included)
// and the fixed drive timing and geometry limits

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

////////////////////
// Register addresses
////////////////////
`define RP_ADDR_CS1     5'o00
`define RP_ADDR_DS      5'o01
`define RP_ADDR_DA      5'o05
`define RP_ADDR_OF      5'o11
`define RP_ADDR_DC      5'o12

////////////////////
// CS1 function codes
////////////////////
`define RP_FUN_NOP      6'o01
`define RP_FUN_SEEK     6'o05
`define RP_FUN_DRVCLR   6'o11
`define RP_FUN_OFFSET   6'o15
`define RP_FUN_CENTER   6'o17
`define RP_FUN_PRESET   6'o21
`define RP_FUN_WRITE    6'o61
`define RP_FUN_WRITEH   6'o63

// Busy cycles per seek
`define RP_SEEK_CYCLES  16
// Highest legal cylinder
`define RP_CYL_MAX      814

`endif
